// File: common/rackbus_params.svh
`ifndef RACKBUS_PARAMS_SVH
`define RACKBUS_PARAMS_SVH

// wishbone target port widths
`define RACKBUS_WB_ADR_BITS 10
`define RACKBUS_WB_DAT_BITS 32

// outbound command widths
`define RACKBUS_RUNCMD_BITS 2
`define RACKBUS_TRIG_BITS 15

// firmware update FIFO depth in 32-bit words
`define FW_FIFO_DEPTH 256

// only the low address bits select a register
`define RACKBUS_DEC_BITS 4

`define CONTROL_ADDR 4'h0
`define FWUPDATE_ADDR 4'h4
`define RUNCMD_ADDR 4'h8
`define TRIG_ADDR 4'hC

`endif

// File: common/surfturf_pkg.sv
`include "rackbus_params.svh"

package surfturf_pkg;

    // one wishbone data word and its address
    typedef logic [`RACKBUS_WB_DAT_BITS-1:0] wb_data_t;
    typedef logic [`RACKBUS_WB_ADR_BITS-1:0] wb_adr_t;

    // one byte enable per data byte
    typedef logic [`RACKBUS_WB_DAT_BITS/8-1:0] wb_sel_t;

    // payloads of the three outbound streams
    typedef logic [7:0] fw_byte_t;
    typedef logic [`RACKBUS_RUNCMD_BITS-1:0] runcmd_t;
    typedef logic [`RACKBUS_TRIG_BITS-1:0] trig_t;

    // master side of the wishbone target port
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_sel_t  sel;
        wb_data_t dat;
    } wb_req_t;

endpackage

// File: rtl/surfturf_regs/fwupdate_fifo.sv
`timescale 1ns/100ps
`include "rackbus_params.svh"

module fwupdate_fifo
    import surfturf_pkg::*;
#(
    parameter int DEPTH = `FW_FIFO_DEPTH
) (
    input  logic     sysclk_i,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     wr_i,
    input  wb_data_t din_i,
    output logic     empty_o,
    output fw_byte_t fw_tdata_o,
    output logic     fw_tvalid_o,
    input  logic     fw_tready_i
);

    localparam int PTR_BITS  = $clog2(DEPTH);
    localparam int BYTE_BITS = $bits(fw_byte_t);
    localparam int IDX_BITS  = $clog2($bits(wb_data_t) / BYTE_BITS);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [PTR_BITS:0]   count_t;
    typedef logic [IDX_BITS-1:0] idx_t;

    wb_data_t mem [DEPTH];
    ptr_t     wr_ptr_q;
    ptr_t     rd_ptr_q;
    count_t   count_q;

    // read side unpacker state
    wb_data_t word_q;
    idx_t     byte_idx_q;
    logic     loaded_q;

    logic     full;
    logic     push;
    logic     byte_taken;
    logic     last_byte;
    logic     fetch;

    assign full       = (count_q == count_t'(DEPTH));
    assign push       = wr_i && !flush_i && !full;
    assign byte_taken = loaded_q && fw_tready_i;
    assign last_byte  = (byte_idx_q == '1);

    // pull the next word as the last byte leaves so words run back to back
    assign fetch = (count_q != '0) && (!loaded_q || (byte_taken && last_byte));

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= din_i;
        end
        if (fetch) begin
            word_q <= mem[rd_ptr_q];
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            loaded_q   <= 1'b0;
            byte_idx_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (fetch) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !fetch) begin
                count_q <= count_q + 1'b1;
            end else if (fetch && !push) begin
                count_q <= count_q - 1'b1;
            end

            // byte index wraps back to zero after the last byte
            if (fetch) begin
                loaded_q   <= 1'b1;
                byte_idx_q <= '0;
            end else if (byte_taken) begin
                byte_idx_q <= byte_idx_q + 1'b1;
                if (last_byte) begin
                    loaded_q <= 1'b0;
                end
            end
        end
    end

    // least significant byte goes out first
    assign fw_tdata_o  = word_q[byte_idx_q*BYTE_BITS +: BYTE_BITS];
    assign fw_tvalid_o = loaded_q;
    assign empty_o     = (count_q == '0) && !loaded_q;

endmodule

// File: rtl/surfturf_regs/surfturf_register_core.sv
`timescale 1ns/100ps
`include "rackbus_params.svh"

module surfturf_register_core
    import surfturf_pkg::*;
(
    input  logic     sysclk_i,
    input  logic     reset_i,

    // wishbone target port
    input  wb_req_t  wb_req_i,
    output logic     wb_ack_o,
    output wb_data_t wb_dat_o,

    // firmware update FIFO write side
    output logic     fifo_wr_o,
    output wb_data_t fifo_din_o,
    output logic     fifo_flush_o,
    input  logic     fifo_empty_i,

    // run command stream
    output runcmd_t  runcmd_tdata_o,
    output logic     runcmd_tvalid_o,
    input  logic     runcmd_tready_i,

    // trigger stream
    output trig_t    trig_tdata_o,
    output logic     trig_tvalid_o,
    input  logic     trig_tready_i
);

    logic [`RACKBUS_DEC_BITS-1:0] reg_addr;
    logic     access_open;
    logic     ack_q;
    logic     wr_cycle;

    logic     ctrl_wr;
    logic     fw_wr;
    logic     runcmd_wr;
    logic     trig_wr;

    logic     flush_q;
    wb_data_t status_word;
    wb_data_t rd_data_q;

    runcmd_t  runcmd_data_q;
    logic     runcmd_valid_q;
    trig_t    trig_data_q;
    logic     trig_valid_q;

    assign reg_addr    = wb_req_i.adr[`RACKBUS_DEC_BITS-1:0];
    assign access_open = wb_req_i.cyc && wb_req_i.stb;

    // one ack per access, issued the cycle after the access opens
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access_open && !ack_q;
        end
    end

    // a dropped cycle kills a pending ack
    assign wb_ack_o = ack_q && wb_req_i.cyc;

    // writes land at the end of the ack cycle
    assign wr_cycle = wb_ack_o && wb_req_i.stb && wb_req_i.we;

    assign ctrl_wr   = wr_cycle && (reg_addr == `CONTROL_ADDR) && wb_req_i.sel[0];
    assign fw_wr     = wr_cycle && (reg_addr == `FWUPDATE_ADDR);
    assign runcmd_wr = wr_cycle && (reg_addr == `RUNCMD_ADDR) && wb_req_i.sel[0];

    // the trigger word spans two bytes, so both enables are needed
    assign trig_wr = wr_cycle && (reg_addr == `TRIG_ADDR)
                     && wb_req_i.sel[0] && wb_req_i.sel[1];

    // flush bit holds the FIFO empty until software clears it
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            flush_q <= 1'b0;
        end else if (ctrl_wr) begin
            flush_q <= wb_req_i.dat[0];
        end
    end

    assign fifo_wr_o    = fw_wr;
    assign fifo_din_o   = wb_req_i.dat;
    assign fifo_flush_o = flush_q;

    // run command holding register
    // a new write wins over a transfer in the same cycle, so valid stays up
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            runcmd_valid_q <= 1'b0;
        end else if (runcmd_wr) begin
            runcmd_valid_q <= 1'b1;
        end else if (runcmd_valid_q && runcmd_tready_i) begin
            runcmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runcmd_wr) begin
            runcmd_data_q <= wb_req_i.dat[`RACKBUS_RUNCMD_BITS-1:0];
        end
    end

    // trigger holding register, same scheme as the run command
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            trig_valid_q <= 1'b0;
        end else if (trig_wr) begin
            trig_valid_q <= 1'b1;
        end else if (trig_valid_q && trig_tready_i) begin
            trig_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (trig_wr) begin
            trig_data_q <= wb_req_i.dat[`RACKBUS_TRIG_BITS-1:0];
        end
    end

    assign runcmd_tdata_o  = runcmd_data_q;
    assign runcmd_tvalid_o = runcmd_valid_q;
    assign trig_tdata_o    = trig_data_q;
    assign trig_tvalid_o   = trig_valid_q;

    // idle bits read 1 once the receiver has taken the pending value
    assign status_word = {{(`RACKBUS_WB_DAT_BITS-4){1'b0}},
                          !trig_valid_q,
                          !runcmd_valid_q,
                          fifo_empty_i,
                          flush_q};

    // read data is captured the cycle before ack and held through it
    always_ff @(posedge sysclk_i) begin
        if (reg_addr == `CONTROL_ADDR) begin
            rd_data_q <= status_word;
        end else begin
            rd_data_q <= '0;
        end
    end

    assign wb_dat_o = rd_data_q;

endmodule

// File: rtl/surfturf_top.sv
`timescale 1ns/100ps

module surfturf_top
    import surfturf_pkg::*;
(
    input  logic     sysclk_i,
    input  logic     reset_i,

    // wishbone target port from the host
    input  wb_req_t  wb_req_i,
    output logic     wb_ack_o,
    output wb_data_t wb_dat_o,

    // outbound streams
    output fw_byte_t fw_tdata_o,
    output logic     fw_tvalid_o,
    input  logic     fw_tready_i,
    output runcmd_t  runcmd_tdata_o,
    output logic     runcmd_tvalid_o,
    input  logic     runcmd_tready_i,
    output trig_t    trig_tdata_o,
    output logic     trig_tvalid_o,
    input  logic     trig_tready_i
);

    logic     fifo_wr;
    wb_data_t fifo_din;
    logic     fifo_flush;
    logic     fifo_empty;

    surfturf_register_core surfturf_register_core_inst (
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .wb_req_i        (wb_req_i),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .fifo_wr_o       (fifo_wr),
        .fifo_din_o      (fifo_din),
        .fifo_flush_o    (fifo_flush),
        .fifo_empty_i    (fifo_empty),
        .runcmd_tdata_o  (runcmd_tdata_o),
        .runcmd_tvalid_o (runcmd_tvalid_o),
        .runcmd_tready_i (runcmd_tready_i),
        .trig_tdata_o    (trig_tdata_o),
        .trig_tvalid_o   (trig_tvalid_o),
        .trig_tready_i   (trig_tready_i)
    );

    fwupdate_fifo fwupdate_fifo_inst (
        .sysclk_i    (sysclk_i),
        .reset_i     (reset_i),
        .flush_i     (fifo_flush),
        .wr_i        (fifo_wr),
        .din_i       (fifo_din),
        .empty_o     (fifo_empty),
        .fw_tdata_o  (fw_tdata_o),
        .fw_tvalid_o (fw_tvalid_o),
        .fw_tready_i (fw_tready_i)
    );

endmodule

// File: src.f
+incdir+common
common/surfturf_pkg.sv
rtl/surfturf_regs/surfturf_register_core.sv
rtl/surfturf_regs/fwupdate_fifo.sv
rtl/surfturf_top.sv
tb/surfturf_assertions.sv
tb/surfturf_tb.sv

// File: tb/surfturf_assertions.sv
`timescale 1ns/100ps

module surfturf_assertions
    import surfturf_pkg::*;
(
    input logic     sysclk_i,
    input logic     reset_i,
    input logic     wb_ack_i,
    input logic     fifo_flush_i,
    input fw_byte_t fw_tdata_i,
    input logic     fw_tvalid_i,
    input logic     fw_tready_i,
    input runcmd_t  runcmd_tdata_i,
    input logic     runcmd_tvalid_i,
    input logic     runcmd_tready_i,
    input trig_t    trig_tdata_i,
    input logic     trig_tvalid_i,
    input logic     trig_tready_i
);

    // number of assertion failures so far
    int fail_count = 0;

    ack_single: assert property (@(posedge sysclk_i) disable iff (reset_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("wb_ack_o stayed high for two cycles");
            fail_count++;
        end

    // a flush may withdraw the current firmware byte
    fw_stable: assert property (@(posedge sysclk_i) disable iff (reset_i || fifo_flush_i)
        fw_tvalid_i && !fw_tready_i |=> fw_tvalid_i && $stable(fw_tdata_i))
        else begin
            $error("firmware byte changed before its transfer");
            fail_count++;
        end

    runcmd_stable: assert property (@(posedge sysclk_i) disable iff (reset_i)
        runcmd_tvalid_i && !runcmd_tready_i |=> runcmd_tvalid_i && $stable(runcmd_tdata_i))
        else begin
            $error("run command changed before its transfer");
            fail_count++;
        end

    trig_stable: assert property (@(posedge sysclk_i) disable iff (reset_i)
        trig_tvalid_i && !trig_tready_i |=> trig_tvalid_i && $stable(trig_tdata_i))
        else begin
            $error("trigger changed before its transfer");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge sysclk_i)
        reset_i |=> !fw_tvalid_i && !runcmd_tvalid_i && !trig_tvalid_i)
        else begin
            $error("a tvalid was high after reset");
            fail_count++;
        end

endmodule

bind surfturf_top surfturf_assertions surfturf_assertions_inst (
    .sysclk_i        (sysclk_i),
    .reset_i         (reset_i),
    .wb_ack_i        (wb_ack_o),
    .fifo_flush_i    (fifo_flush),
    .fw_tdata_i      (fw_tdata_o),
    .fw_tvalid_i     (fw_tvalid_o),
    .fw_tready_i     (fw_tready_i),
    .runcmd_tdata_i  (runcmd_tdata_o),
    .runcmd_tvalid_i (runcmd_tvalid_o),
    .runcmd_tready_i (runcmd_tready_i),
    .trig_tdata_i    (trig_tdata_o),
    .trig_tvalid_i   (trig_tvalid_o),
    .trig_tready_i   (trig_tready_i)
);

// File: tb/surfturf_tb.sv
`timescale 1ns/100ps
`include "rackbus_params.svh"

module surfturf_tb
    import surfturf_pkg::*;
();

    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int STATUS_POLLS   = 100;
    localparam int S_FW           = 0;
    localparam int S_RUN          = 1;
    localparam int S_TRIG         = 2;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_STREAM, OP_IDLE, OP_HOLD, OP_COUNT} op_e;

    // for stream, hold and count rows the address field selects the stream
    typedef struct packed {
        op_e      op;
        wb_adr_t  adr;
        wb_data_t dat;
        wb_sel_t  sel;
        wb_data_t exp;
    } step_t;

    logic       sysclk;
    logic       reset;
    wb_req_t    wb_req;
    logic       wb_ack;
    wb_data_t   wb_dat;
    fw_byte_t   fw_tdata;
    runcmd_t    runcmd_tdata;
    trig_t      trig_tdata;
    logic       fw_tvalid;
    logic       runcmd_tvalid;
    logic       trig_tvalid;
    logic [2:0] tready;
    logic [2:0] hold;
    wb_data_t   fw_rx [$];
    wb_data_t   run_rx [$];
    wb_data_t   trig_rx [$];
    step_t      steps [$];
    string      stream_names [3] = '{"fw_tdata_o", "runcmd_tdata_o", "trig_tdata_o"};

    surfturf_top surfturf_top_inst (
        .sysclk_i        (sysclk),
        .reset_i         (reset),
        .wb_req_i        (wb_req),
        .wb_ack_o        (wb_ack),
        .wb_dat_o        (wb_dat),
        .fw_tdata_o      (fw_tdata),
        .fw_tvalid_o     (fw_tvalid),
        .fw_tready_i     (tready[S_FW]),
        .runcmd_tdata_o  (runcmd_tdata),
        .runcmd_tvalid_o (runcmd_tvalid),
        .runcmd_tready_i (tready[S_RUN]),
        .trig_tdata_o    (trig_tdata),
        .trig_tvalid_o   (trig_tvalid),
        .trig_tready_i   (tready[S_TRIG])
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // stream receivers: each tready is high three cycles in four unless held,
    // and every transfer that the next edge completes is queued
    initial begin
        logic [2:0] held;
        tready = '0;
        forever begin
            @(posedge sysclk);
            held = hold;
            #DRIVE_DELAY;
            tready = ~held & 3'($urandom | $urandom);
            #1;
            if (fw_tvalid && tready[S_FW]) fw_rx.push_back(wb_data_t'(fw_tdata));
            if (runcmd_tvalid && tready[S_RUN]) run_rx.push_back(wb_data_t'(runcmd_tdata));
            if (trig_tvalid && tready[S_TRIG]) trig_rx.push_back(wb_data_t'(trig_tdata));
        end
    end

    task automatic fail_with(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, wb_data_t actual, wb_data_t expected);
        if (actual !== expected) begin
            fail_with($sformatf("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    always @(surfturf_top_inst.surfturf_assertions_inst.fail_count) begin
        if (surfturf_top_inst.surfturf_assertions_inst.fail_count != 0) begin
            fail_with("a protocol assertion in surfturf_assertions failed");
        end
    end

    task automatic next_cycle(inout int waited, input string what);
        if (waited >= TIMEOUT_CYCLES) begin
            fail_with($sformatf("timeout: no %s within %0d cycles", what, waited));
        end else begin
            @(posedge sysclk);
            #DRIVE_DELAY;
            waited++;
        end
    endtask

    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t dat,
                              input wb_sel_t sel, output wb_data_t rdata);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.sel = sel;
        wb_req.dat = dat;
        do begin
            next_cycle(waited, "bus acknowledge");
        end while (!wb_ack);
        // read data is valid in the ack cycle, a write lands on the next edge
        rdata = wb_dat;
        @(posedge sysclk);
        #DRIVE_DELAY;
        wb_req = '0;
    endtask

    task automatic wait_status(wb_data_t exp);
        wb_data_t rdata;
        int       tries;
        tries = 0;
        bus_access(1'b0, `CONTROL_ADDR, '0, 4'hF, rdata);
        while (rdata !== exp) begin
            if (tries >= STATUS_POLLS) begin
                fail_with($sformatf("timeout: status never read 0x%0h, last 0x%0h", exp, rdata));
            end else begin
                bus_access(1'b0, `CONTROL_ADDR, '0, 4'hF, rdata);
                tries++;
            end
        end
    endtask

    function automatic int rx_count(int id);
        case (id)
            S_FW:    return fw_rx.size();
            S_RUN:   return run_rx.size();
            default: return trig_rx.size();
        endcase
    endfunction

    task automatic expect_stream(int id, wb_data_t exp);
        int       waited;
        wb_data_t got;
        waited = 0;
        while (rx_count(id) == 0) begin
            next_cycle(waited, {"transfer on ", stream_names[id]});
        end
        case (id)
            S_FW:    got = fw_rx.pop_front();
            S_RUN:   got = run_rx.pop_front();
            default: got = trig_rx.pop_front();
        endcase
        check_value(stream_names[id], got, exp);
    endtask

    task automatic add_step(op_e op, int adr, wb_data_t dat, wb_sel_t sel, wb_data_t exp);
        steps.push_back({op, wb_adr_t'(adr), dat, sel, exp});
    endtask

    // all words are written first, so several queue up in the FIFO,
    // then their bytes are expected in write order, least significant first
    task automatic push_words(int n, bit expect_bytes);
        wb_data_t words [$];
        for (int i = 0; i < n; i++) begin
            words.push_back($urandom);
            add_step(OP_WRITE, `FWUPDATE_ADDR, words[i], 4'hF, '0);
        end
        for (int i = 0; i < n && expect_bytes; i++) begin
            for (int b = 0; b < 4; b++) begin
                add_step(OP_STREAM, S_FW, '0, '0, (words[i] >> (8 * b)) & 32'hFF);
            end
        end
    endtask

    task automatic build_table();
        add_step(OP_READ, `CONTROL_ADDR, '0, 4'hF, 32'hE);
        push_words(8, 1'b1);
        add_step(OP_IDLE, 0, '0, '0, 32'hE);
        add_step(OP_COUNT, S_FW, '0, '0, 0);
        // run command held back by the receiver, only the low two bits count
        add_step(OP_HOLD, S_RUN, 1, '0, '0);
        add_step(OP_WRITE, `RUNCMD_ADDR, 32'h5A5A_A5A6, 4'h1, '0);
        add_step(OP_READ, `CONTROL_ADDR, '0, 4'hF, 32'hA);
        add_step(OP_COUNT, S_RUN, '0, '0, 0);
        add_step(OP_READ, `CONTROL_ADDR, '0, 4'hF, 32'hA);
        add_step(OP_HOLD, S_RUN, 0, '0, '0);
        add_step(OP_STREAM, S_RUN, '0, '0, 32'h5A5A_A5A6 & 32'h3);
        add_step(OP_IDLE, 0, '0, '0, 32'hE);
        add_step(OP_COUNT, S_RUN, '0, '0, 0);
        // trigger needs both low byte enables
        add_step(OP_WRITE, `TRIG_ADDR, 32'hDEAD_6B3C, 4'h3, '0);
        add_step(OP_STREAM, S_TRIG, '0, '0, 32'hDEAD_6B3C & 32'h7FFF);
        add_step(OP_IDLE, 0, '0, '0, 32'hE);
        add_step(OP_WRITE, `TRIG_ADDR, 32'h0000_1234, 4'h1, '0);
        add_step(OP_READ, `CONTROL_ADDR, '0, 4'hF, 32'hE);
        add_step(OP_COUNT, S_TRIG, '0, '0, 0);
        // words parked in the FIFO are discarded by the flush
        add_step(OP_HOLD, S_FW, 1, '0, '0);
        push_words(3, 1'b0);
        add_step(OP_READ, `CONTROL_ADDR, '0, 4'hF, 32'hC);
        add_step(OP_WRITE, `CONTROL_ADDR, 32'h1, 4'h1, '0);
        add_step(OP_IDLE, 0, '0, '0, 32'hF);
        push_words(2, 1'b0);
        add_step(OP_HOLD, S_FW, 0, '0, '0);
        add_step(OP_IDLE, 0, '0, '0, 32'hF);
        add_step(OP_WRITE, `CONTROL_ADDR, 32'h0, 4'h1, '0);
        add_step(OP_IDLE, 0, '0, '0, 32'hE);
        add_step(OP_COUNT, S_FW, '0, '0, 0);
        push_words(2, 1'b1);
        add_step(OP_IDLE, 0, '0, '0, 32'hE);
        add_step(OP_COUNT, S_FW, '0, '0, 0);
    endtask

    task automatic apply_step(step_t s);
        wb_data_t rdata;
        case (s.op)
            OP_WRITE:  bus_access(1'b1, s.adr, s.dat, s.sel, rdata);
            OP_READ: begin
                bus_access(1'b0, s.adr, '0, s.sel, rdata);
                check_value("wb_dat_o", rdata, s.exp);
            end
            OP_STREAM: expect_stream(s.adr, s.exp);
            OP_IDLE:   wait_status(s.exp);
            OP_HOLD:   hold[s.adr] = s.dat[0];
            default:   check_value({stream_names[s.adr], " count"}, rx_count(s.adr), s.exp);
        endcase
    endtask

    initial begin
        void'($urandom(32'h19f2_cd88));
        reset  = 1'b1;
        wb_req = '0;
        hold   = '0;
        build_table();
        repeat (5) @(posedge sysclk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_value("fw_tvalid_o", fw_tvalid, 0);
        check_value("runcmd_tvalid_o", runcmd_tvalid, 0);
        check_value("trig_tvalid_o", trig_tvalid, 0);
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
